// ==== hw/front_end_pkg.sv ====
/*
 * front end package
 * shared widths, RV32I opcodes, the instruction word union and
 * the datapath select encodings used by fetch, decode and predict
 */
package front_end_pkg;

	localparam int xlen = 32;

	// default depth of the branch target buffer, power of two
	localparam int btb_default_entries = 16;

	// architectural x0
	localparam logic [4:0] zero_reg = 5'd0;

	////////////////////////////////////////
	// major opcodes
	////////////////////////////////////////
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_system = 7'b1110011;

	////////////////////////////////////////
	// instruction formats, msb first
	////////////////////////////////////////
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered across the word
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_t;

	////////////////////////////////////////
	// datapath selects
	////////////////////////////////////////
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
		alu_or, alu_xor, alu_sll, alu_srl, alu_sra
	} alu_func_t;

	typedef enum logic [1:0] {
		opa_rs1, opa_pc, opa_zero
	} opa_sel_t;

	typedef enum logic [2:0] {
		opb_rs2, opb_i_imm, opb_s_imm, opb_b_imm, opb_u_imm, opb_j_imm, opb_four
	} opb_sel_t;

endpackage

// ==== hw/fetch_bus_if.sv ====
/*
 * fetch bus
 * carries the fetched word and its pc pair from fetch to decode
 */
`timescale 1ns/1ps

interface fetch_bus_if;
	import front_end_pkg::*;

	instr_t          inst;
	logic [xlen-1:0] pc;
	// pc plus 4, handed down with the word
	logic [xlen-1:0] npc;
	// mirrors imem_valid, same cycle, no handshake behind it
	logic            fetch_valid;

	modport fetch_src (output inst, pc, npc, fetch_valid);
	modport decode_sink (input inst, pc, npc, fetch_valid);

endinterface

// ==== hw/fetch_unit.sv ====
/*
 * fetch unit
 * pc register, 32-bit half select out of the 64-bit memory word
 * and next pc choice: squash, then prediction, then pc plus 4
 */
`timescale 1ns/1ps

module fetch_unit (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [63:0]                      imem_data,
	input  logic                             imem_valid,
	input  logic                             squash,
	input  logic [front_end_pkg::xlen-1:0]   squash_target,
	input  logic                             advance,
	input  logic                             take_branch,
	input  logic [front_end_pkg::xlen-1:0]   predict_target,
	output logic [front_end_pkg::xlen-1:0]   imem_addr,
	fetch_bus_if.fetch_src                   bus
);
	import front_end_pkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus_4;
	logic [xlen-1:0] next_pc;

	assign pc_plus_4 = pc + xlen'(4);

	// memory is addressed by 8-byte word
	assign imem_addr = {pc[xlen-1:3], 3'b000};

	// bit 2 picks which instruction of the pair
	assign bus.inst        = pc[2] ? imem_data[63:32] : imem_data[31:0];
	assign bus.pc          = pc;
	assign bus.npc         = pc_plus_4;
	assign bus.fetch_valid = imem_valid;

	// squash wins over stall, illegal and prediction
	always_comb begin
		next_pc = pc;
		if (squash) begin
			next_pc = squash_target;
		end else if (advance) begin
			next_pc = take_branch ? predict_target : pc_plus_4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

// ==== hw/inst_decoder.sv ====
/*
 * RV32I decoder
 * purely combinational, turns the fetched word into alu and operand
 * selects, memory and branch flags, register requests and legality
 */
`timescale 1ns/1ps

module inst_decoder (
	fetch_bus_if.decode_sink            bus,
	input  logic                        stall,
	output logic                        id_valid,
	output logic                        illegal,
	output logic                        halt,
	output front_end_pkg::alu_func_t    alu_func,
	output front_end_pkg::opa_sel_t     opa_select,
	output front_end_pkg::opb_sel_t     opb_select,
	output logic                        rd_mem,
	output logic                        wr_mem,
	output logic                        cond_branch,
	output logic                        uncond_branch,
	output logic                        is_jal,
	output logic [4:0]                  dest_reg_idx,
	output logic                        rs1_req,
	output logic [4:0]                  rs1_idx,
	output logic                        rs2_req,
	output logic [4:0]                  rs2_idx
);
	import front_end_pkg::*;

	instr_t inst;
	logic   has_rd;
	logic   uses_rs1;
	logic   uses_rs2;

	assign inst = bus.inst;

	always_comb begin
		illegal       = 1'b0;
		halt          = 1'b0;
		alu_func      = alu_add;
		opa_select    = opa_rs1;
		opb_select    = opb_rs2;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		is_jal        = 1'b0;
		has_rd        = 1'b0;
		uses_rs1      = 1'b1;
		uses_rs2      = 1'b0;

		case (inst.r.opcode)
			opc_lui: begin
				opa_select = opa_zero;
				opb_select = opb_u_imm;
				has_rd     = 1'b1;
				uses_rs1   = 1'b0;
			end
			opc_auipc: begin
				opa_select = opa_pc;
				opb_select = opb_u_imm;
				has_rd     = 1'b1;
				uses_rs1   = 1'b0;
			end
			// jumps compute the link value, pc plus 4
			opc_jal: begin
				opa_select    = opa_pc;
				opb_select    = opb_four;
				uncond_branch = 1'b1;
				is_jal        = 1'b1;
				has_rd        = 1'b1;
				uses_rs1      = 1'b0;
			end
			opc_jalr: begin
				opb_select    = opb_four;
				uncond_branch = 1'b1;
				has_rd        = 1'b1;
				illegal       = (inst.i.funct3 != 3'b000);
			end
			opc_branch: begin
				opa_select  = opa_pc;
				opb_select  = opb_b_imm;
				cond_branch = 1'b1;
				uses_rs2    = 1'b1;
				// compare flavour from funct3
				case (inst.b.funct3)
					3'b000, 3'b001: alu_func = alu_sub;
					3'b100, 3'b101: alu_func = alu_slt;
					3'b110, 3'b111: alu_func = alu_sltu;
					default:        illegal  = 1'b1;
				endcase
			end
			opc_load: begin
				opb_select = opb_i_imm;
				rd_mem     = 1'b1;
				has_rd     = 1'b1;
				// lb lh lw lbu lhu only
				illegal    = (inst.i.funct3 == 3'b011) || (inst.i.funct3[2:1] == 2'b11);
			end
			opc_store: begin
				opb_select = opb_s_imm;
				wr_mem     = 1'b1;
				uses_rs2   = 1'b1;
				illegal    = (inst.s.funct3[2] || inst.s.funct3 == 3'b011);
			end
			opc_op_imm: begin
				opb_select = opb_i_imm;
				has_rd     = 1'b1;
				case (inst.i.funct3)
					3'b000: alu_func = alu_add;
					3'b010: alu_func = alu_slt;
					3'b011: alu_func = alu_sltu;
					3'b100: alu_func = alu_xor;
					3'b110: alu_func = alu_or;
					3'b111: alu_func = alu_and;
					// shifts keep funct7 in the upper immediate
					3'b001: begin
						alu_func = alu_sll;
						illegal  = (inst.r.funct7 != 7'b0000000);
					end
					default: begin
						alu_func = inst.r.funct7[5] ? alu_sra : alu_srl;
						illegal  = ({inst.r.funct7[6], inst.r.funct7[4:0]} != 6'b0);
					end
				endcase
			end
			opc_op: begin
				has_rd   = 1'b1;
				uses_rs2 = 1'b1;
				case ({inst.r.funct7, inst.r.funct3})
					10'b0000000_000: alu_func = alu_add;
					10'b0100000_000: alu_func = alu_sub;
					10'b0000000_001: alu_func = alu_sll;
					10'b0000000_010: alu_func = alu_slt;
					10'b0000000_011: alu_func = alu_sltu;
					10'b0000000_100: alu_func = alu_xor;
					10'b0000000_101: alu_func = alu_srl;
					10'b0100000_101: alu_func = alu_sra;
					10'b0000000_110: alu_func = alu_or;
					10'b0000000_111: alu_func = alu_and;
					default:         illegal  = 1'b1;
				endcase
			end
			// only ecall and ebreak, both stop the core
			opc_system: begin
				if (inst.i.imm[11:1] == 11'b0 && inst.i.rs1 == 5'd0 &&
				    inst.i.funct3 == 3'b000 && inst.i.rd == 5'd0) begin
					halt = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
		endcase
	end

	// unrequested indices read as zero
	assign rs1_req      = uses_rs1 && !illegal;
	assign rs2_req      = uses_rs2 && !illegal;
	assign rs1_idx      = rs1_req ? inst.r.rs1 : 5'd0;
	assign rs2_idx      = rs2_req ? inst.s.rs2 : 5'd0;
	assign dest_reg_idx = (has_rd && !illegal) ? inst.r.rd : zero_reg;

	// stall only drops the valid, controls still show the decode
	assign id_valid = !illegal && bus.fetch_valid && !stall;

endmodule

// ==== hw/branch_target_buffer.sv ====
/*
 * branch target buffer
 * direct mapped and tagged, one taken bit per entry
 * looked up combinationally at fetch, trained by execute resolutions
 */
`timescale 1ns/1ps

module branch_target_buffer #(
	parameter int btb_entries = front_end_pkg::btb_default_entries
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [front_end_pkg::xlen-1:0]   lookup_pc,
	output logic                             hit,
	output logic                             predict_taken,
	output logic [front_end_pkg::xlen-1:0]   target,
	input  logic                             resolve_valid,
	input  logic [front_end_pkg::xlen-1:0]   resolve_pc,
	input  logic [front_end_pkg::xlen-1:0]   resolve_target,
	input  logic                             resolve_taken
);
	import front_end_pkg::*;

	// index sits just above the byte offset, tag is the rest
	localparam int idx_w = $clog2(btb_entries);
	localparam int tag_w = xlen - 2 - idx_w;

	logic [btb_entries-1:0] entry_valid;
	logic [tag_w-1:0]       entry_tag [btb_entries];
	logic [btb_entries-1:0] entry_taken;
	logic [xlen-1:0]        entry_target [btb_entries];

	logic [idx_w-1:0] rd_idx;
	logic [tag_w-1:0] rd_tag;
	logic [idx_w-1:0] wr_idx;
	logic [tag_w-1:0] wr_tag;

	assign rd_idx = lookup_pc[idx_w+1:2];
	assign rd_tag = lookup_pc[xlen-1:idx_w+2];
	assign wr_idx = resolve_pc[idx_w+1:2];
	assign wr_tag = resolve_pc[xlen-1:idx_w+2];

	////////////////////////////////////////
	// read side
	////////////////////////////////////////
	assign hit           = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
	assign predict_taken = entry_taken[rd_idx];
	assign target        = entry_target[rd_idx];

	////////////////////////////////////////
	// write side, seen by lookups next cycle
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
		end else if (resolve_valid) begin
			entry_valid[wr_idx] <= 1'b1;
		end
	end

	// an aliasing pc just takes the slot over
	always_ff @(posedge clock) begin
		if (resolve_valid) begin
			entry_tag[wr_idx]   <= wr_tag;
			entry_taken[wr_idx] <= resolve_taken;
			// not-taken keeps the old target
			if (resolve_taken) begin
				entry_target[wr_idx] <= resolve_target;
			end
		end
	end

endmodule

// ==== hw/dispatch_stage.sv ====
/*
 * dispatch stage
 * RV32I front end top: fetch, decode and branch prediction
 * outputs describe the instruction at the current pc in the same cycle
 */
`timescale 1ns/1ps

module dispatch_stage #(
	parameter int btb_entries = front_end_pkg::btb_default_entries
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             stall,
	input  logic                             squash,
	input  logic [front_end_pkg::xlen-1:0]   squash_target,
	input  logic [63:0]                      imem_data,
	input  logic                             imem_valid,
	input  logic                             resolve_valid,
	input  logic [front_end_pkg::xlen-1:0]   resolve_pc,
	input  logic [front_end_pkg::xlen-1:0]   resolve_target,
	input  logic                             resolve_taken,
	output logic [front_end_pkg::xlen-1:0]   imem_addr,
	output logic                             id_valid,
	output logic [front_end_pkg::xlen-1:0]   id_pc,
	output logic [front_end_pkg::xlen-1:0]   id_npc,
	output logic [front_end_pkg::xlen-1:0]   id_inst,
	output logic                             take_branch,
	output logic                             illegal,
	output logic                             halt,
	output front_end_pkg::alu_func_t         alu_func,
	output front_end_pkg::opa_sel_t          opa_select,
	output front_end_pkg::opb_sel_t          opb_select,
	output logic                             rd_mem,
	output logic                             wr_mem,
	output logic                             cond_branch,
	output logic                             uncond_branch,
	output logic [4:0]                       dest_reg_idx,
	output logic                             rs1_req,
	output logic [4:0]                       rs1_idx,
	output logic                             rs2_req,
	output logic [4:0]                       rs2_idx
);
	import front_end_pkg::*;

	logic            is_jal;
	logic            btb_hit;
	logic            btb_taken;
	logic [xlen-1:0] btb_target;

	fetch_bus_if bus ();

	assign id_pc   = bus.pc;
	assign id_npc  = bus.npc;
	assign id_inst = bus.inst;

	// predict only for conditional branches and jal, never jalr
	assign take_branch = btb_hit && btb_taken && (cond_branch || is_jal);

	fetch_unit u_fetch (
		.clock          (clock),
		.reset          (reset),
		.imem_data      (imem_data),
		.imem_valid     (imem_valid),
		.squash         (squash),
		.squash_target  (squash_target),
		.advance        (id_valid),
		.take_branch    (take_branch),
		.predict_target (btb_target),
		.imem_addr      (imem_addr),
		.bus            (bus.fetch_src)
	);

	inst_decoder u_decode (
		.bus           (bus.decode_sink),
		.stall         (stall),
		.id_valid      (id_valid),
		.illegal       (illegal),
		.halt          (halt),
		.alu_func      (alu_func),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.rd_mem        (rd_mem),
		.wr_mem        (wr_mem),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.is_jal        (is_jal),
		.dest_reg_idx  (dest_reg_idx),
		.rs1_req       (rs1_req),
		.rs1_idx       (rs1_idx),
		.rs2_req       (rs2_req),
		.rs2_idx       (rs2_idx)
	);

	branch_target_buffer #(
		.btb_entries (btb_entries)
	) u_btb (
		.clock          (clock),
		.reset          (reset),
		.lookup_pc      (bus.pc),
		.hit            (btb_hit),
		.predict_taken  (btb_taken),
		.target         (btb_target),
		.resolve_valid  (resolve_valid),
		.resolve_pc     (resolve_pc),
		.resolve_target (resolve_target),
		.resolve_taken  (resolve_taken)
	);

endmodule

// ==== dv/tb_dispatch_stage.sv ====
/*
 * dispatch stage testbench
 * random RV32I program in a 64-bit memory model, reference decoder,
 * model pc and model btb, concurrent checks, watchdog
 */
`timescale 1ns/1ps

module tb_dispatch_stage;
	import front_end_pkg::*;

	localparam int btb_entries = 16;
	localparam int idx_w       = $clog2(btb_entries);
	localparam int mem_words   = 128;
	localparam int n_random    = 500;
	localparam int n_directed  = 30;
	localparam logic [31:0] p_branch = 32'h0000_0100;
	localparam logic [31:0] p_jal    = 32'h0000_0104;
	localparam logic [31:0] p_alias  = 32'h0000_0140;
	localparam logic [31:0] t_branch = 32'h0000_0180;
	localparam logic [31:0] t_jal    = 32'h0000_01c0;

	// expected view of one decoded word, 32 bits
	typedef struct packed {
		logic       illegal;
		logic       halt;
		alu_func_t  alu;
		opa_sel_t   opa;
		opb_sel_t   opb;
		logic       rd_mem;
		logic       wr_mem;
		logic       cond;
		logic       uncond;
		logic [4:0] dest;
		logic       rs1_req;
		logic [4:0] rs1_idx;
		logic       rs2_req;
		logic [4:0] rs2_idx;
	} ctrl_t;

	logic        clock;
	logic        reset;
	logic        stall;
	logic        squash;
	logic [31:0] squash_target;
	logic [63:0] imem_data;
	logic        imem_valid;
	logic        resolve_valid;
	logic [31:0] resolve_pc;
	logic [31:0] resolve_target;
	logic        resolve_taken;
	logic [31:0] imem_addr;
	logic        id_valid;
	logic [31:0] id_pc;
	logic [31:0] id_npc;
	logic [31:0] id_inst;
	logic        take_branch;
	logic        illegal;
	logic        halt;
	alu_func_t   alu_func;
	opa_sel_t    opa_select;
	opb_sel_t    opb_select;
	logic        rd_mem;
	logic        wr_mem;
	logic        cond_branch;
	logic        uncond_branch;
	logic [4:0]  dest_reg_idx;
	logic        rs1_req;
	logic [4:0]  rs1_idx;
	logic        rs2_req;
	logic [4:0]  rs2_idx;

	logic [63:0] mem [mem_words];

	// model state
	logic [31:0]      model_pc;
	logic             m_valid [btb_entries];
	logic [29-idx_w:0] m_tag [btb_entries];
	logic             m_taken [btb_entries];
	logic [31:0]      m_target [btb_entries];

	logic [63:0]      exp_line;
	logic [31:0]      exp_word;
	ctrl_t            exp_ctrl;
	ctrl_t            act_ctrl;
	logic             exp_valid;
	logic [idx_w-1:0] look_idx;
	logic             exp_take;
	logic [31:0]      exp_target;
	int               error_count = 0;

	dispatch_stage #(
		.btb_entries (btb_entries)
	) dut (.*);

	// same-cycle memory, 128 words so address bits 9:3
	assign imem_data = mem[imem_addr[9:3]];

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////
	// reference decode
	////////////////////////////////////////

	// shared funct3 meaning of op and op_imm
	function automatic alu_func_t alu_of(input logic [2:0] f3);
		case (f3)
			3'd0:    return alu_add;
			3'd1:    return alu_sll;
			3'd2:    return alu_slt;
			3'd3:    return alu_sltu;
			3'd4:    return alu_xor;
			3'd5:    return alu_srl;
			3'd6:    return alu_or;
			default: return alu_and;
		endcase
	endfunction

	function automatic ctrl_t ref_decode(input logic [31:0] w);
		ctrl_t      c;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       wr_rd;
		logic       rd1;
		logic       rd2;
		f3    = w[14:12];
		f7    = w[31:25];
		c     = '0;
		wr_rd = 1'b1;
		rd1   = 1'b1;
		rd2   = 1'b0;
		case (w[6:0])
			opc_lui: begin
				c.opa = opa_zero;
				c.opb = opb_u_imm;
				rd1   = 1'b0;
			end
			opc_auipc: begin
				c.opa = opa_pc;
				c.opb = opb_u_imm;
				rd1   = 1'b0;
			end
			opc_jal: begin
				c.opa    = opa_pc;
				c.opb    = opb_four;
				c.uncond = 1'b1;
				rd1      = 1'b0;
			end
			opc_jalr: begin
				c.opb     = opb_four;
				c.uncond  = 1'b1;
				c.illegal = (f3 != 3'd0);
			end
			opc_branch: begin
				c.opa     = opa_pc;
				c.opb     = opb_b_imm;
				c.cond    = 1'b1;
				wr_rd     = 1'b0;
				rd2       = 1'b1;
				c.illegal = (f3[2:1] == 2'b01);
				// beq bne subtract, the rest compare
				c.alu     = !f3[2] ? alu_sub : (f3[1] ? alu_sltu : alu_slt);
			end
			opc_load: begin
				c.opb     = opb_i_imm;
				c.rd_mem  = 1'b1;
				c.illegal = !(f3 <= 3'd2 || f3 == 3'd4 || f3 == 3'd5);
			end
			opc_store: begin
				c.opb     = opb_s_imm;
				c.wr_mem  = 1'b1;
				wr_rd     = 1'b0;
				rd2       = 1'b1;
				c.illegal = (f3 > 3'd2);
			end
			opc_op_imm: begin
				c.opb = opb_i_imm;
				c.alu = alu_of(f3);
				if (f3 == 3'd1) begin
					c.illegal = (f7 != 7'h00);
				end else if (f3 == 3'd5 && f7 == 7'h20) begin
					c.alu = alu_sra;
				end else if (f3 == 3'd5) begin
					c.illegal = (f7 != 7'h00);
				end
			end
			opc_op: begin
				rd2   = 1'b1;
				c.alu = alu_of(f3);
				if (f7 == 7'h20 && f3 == 3'd0) begin
					c.alu = alu_sub;
				end else if (f7 == 7'h20 && f3 == 3'd5) begin
					c.alu = alu_sra;
				end else if (f7 != 7'h00) begin
					c.illegal = 1'b1;
				end
			end
			// ecall or ebreak only
			opc_system: begin
				wr_rd     = 1'b0;
				c.halt    = (w[31:21] == 11'd0 && w[19:7] == 13'd0);
				c.illegal = !c.halt;
			end
			default: c.illegal = 1'b1;
		endcase
		c.dest    = wr_rd ? w[11:7] : zero_reg;
		c.rs1_req = rd1;
		c.rs1_idx = rd1 ? w[19:15] : 5'd0;
		c.rs2_req = rd2;
		c.rs2_idx = rd2 ? w[24:20] : 5'd0;
		return c;
	endfunction

	// mostly legal words, about one in sixteen illegal
	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [2:0]  mem_f3;
		logic [6:0]  f7;
		r      = $urandom;
		f3     = r[14:12];
		mem_f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
		case ($urandom % 16)
			0:       return {r[31:7], opc_lui};
			1:       return {r[31:7], opc_auipc};
			2, 14:   return {r[31:7], opc_jal};
			3:       return {r[31:15], 3'b000, r[11:7], opc_jalr};
			4, 15:   return {r[31:15], (f3[2] ? f3 : {2'b00, f3[0]}), r[11:7], opc_branch};
			5:       return {r[31:15], (f3[2] ? {2'b10, f3[0]} : mem_f3), r[11:7], opc_load};
			6:       return {r[31:15], mem_f3, r[11:7], opc_store};
			7, 8: begin
				f7 = (f3 == 3'd1) ? 7'h00 : ((f3 == 3'd5) ? {1'b0, r[30], 5'd0} : r[31:25]);
				return {f7, r[24:15], f3, r[11:7], opc_op_imm};
			end
			9, 10, 11: begin
				f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'd0} : 7'h00;
				return {f7, r[24:15], f3, r[11:7], opc_op};
			end
			12:      return r[0] ? 32'h0010_0073 : 32'h0000_0073;
			// unknown opcode, or a multiply encoding
			default: return r[0] ? {r[31:7], 7'b1111111} : {7'b0000001, r[24:7], opc_op};
		endcase
	endfunction

	////////////////////////////////////////
	// model pc and btb
	////////////////////////////////////////
	assign exp_line   = mem[model_pc[9:3]];
	assign exp_word   = model_pc[2] ? exp_line[63:32] : exp_line[31:0];
	assign exp_ctrl   = ref_decode(exp_word);
	assign exp_valid  = !exp_ctrl.illegal && imem_valid && !stall;
	assign look_idx   = model_pc[idx_w+1:2];
	assign exp_target = m_target[look_idx];
	assign exp_take   = m_valid[look_idx] && m_taken[look_idx] &&
		(m_tag[look_idx] == model_pc[31:idx_w+2]) &&
		(exp_word[6:0] == opc_branch || exp_word[6:0] == opc_jal);

	assign act_ctrl = {illegal, halt, alu_func, opa_select, opb_select, rd_mem, wr_mem,
		cond_branch, uncond_branch, dest_reg_idx, rs1_req, rs1_idx, rs2_req, rs2_idx};

	always @(posedge clock) begin
		if (reset) begin
			model_pc <= 32'd0;
			for (int e = 0; e < btb_entries; e++) begin
				m_valid[e] <= 1'b0;
			end
		end else begin
			// squash first, then predicted or sequential advance
			if (squash) begin
				model_pc <= squash_target;
			end else if (exp_valid) begin
				model_pc <= exp_take ? exp_target : model_pc + 32'd4;
			end
			if (resolve_valid) begin
				m_valid[resolve_pc[idx_w+1:2]] <= 1'b1;
				m_tag[resolve_pc[idx_w+1:2]]   <= resolve_pc[31:idx_w+2];
				m_taken[resolve_pc[idx_w+1:2]] <= resolve_taken;
				if (resolve_taken) begin
					m_target[resolve_pc[idx_w+1:2]] <= resolve_target;
				end
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	task automatic flag_mismatch(input string what);
		error_count++;
		$display("MISMATCH %0t: %s", $time, what);
	endtask

	a_reset: assert property (@(posedge clock) $fell(reset) |-> imem_addr == 32'd0 && !take_branch)
		else flag_mismatch("fetch address or prediction not clear after reset");
	a_addr: assert property (@(posedge clock) disable iff (reset)
		imem_addr == {model_pc[31:3], 3'b000})
		else flag_mismatch($sformatf("imem_addr %h, model pc %h",
			$sampled(imem_addr), $sampled(model_pc)));
	a_fetch: assert property (@(posedge clock) disable iff (reset)
		id_pc == model_pc && id_npc == model_pc + 32'd4 && id_inst == exp_word)
		else flag_mismatch($sformatf("id_pc %h id_inst %h, expected %h %h",
			$sampled(id_pc), $sampled(id_inst), $sampled(model_pc), $sampled(exp_word)));
	a_valid: assert property (@(posedge clock) disable iff (reset)
		illegal == exp_ctrl.illegal && id_valid == exp_valid)
		else flag_mismatch("illegal or id_valid differs from reference");
	a_ctrl: assert property (@(posedge clock) disable iff (reset)
		!exp_ctrl.illegal |-> act_ctrl == exp_ctrl)
		else flag_mismatch($sformatf("decode of %h: %h, expected %h",
			$sampled(exp_word), $sampled(act_ctrl), $sampled(exp_ctrl)));
	a_take: assert property (@(posedge clock) disable iff (reset) take_branch == exp_take)
		else flag_mismatch("take_branch differs from model btb");
	// next pc rules
	a_hold: assert property (@(posedge clock) disable iff (reset)
		(stall || !imem_valid || illegal) && !squash |=> id_pc == $past(id_pc))
		else flag_mismatch("pc moved while not dispatching");
	a_seq: assert property (@(posedge clock) disable iff (reset)
		id_valid && !take_branch && !squash |=> id_pc == $past(id_pc) + 32'd4)
		else flag_mismatch("sequential pc not old pc plus 4");
	a_pred: assert property (@(posedge clock) disable iff (reset)
		id_valid && take_branch && !squash |=> id_pc == $past(exp_target))
		else flag_mismatch("predicted pc not the trained target");
	a_squash: assert property (@(posedge clock) disable iff (reset)
		squash |=> id_pc == $past(squash_target))
		else flag_mismatch("squash target not loaded");

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic train(input logic [31:0] pc, input logic [31:0] tgt, input logic taken);
		resolve_valid  = 1'b1;
		resolve_pc     = pc;
		resolve_target = tgt;
		resolve_taken  = taken;
		next_cycle();
		resolve_valid  = 1'b0;
	endtask

	// squash pulse, optionally under stall
	task automatic redirect(input logic [31:0] target, input logic hold);
		squash        = 1'b1;
		squash_target = target;
		stall         = hold;
		next_cycle();
		squash        = 1'b0;
		stall         = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		void'($urandom(32'hc1b3_8c06));
		reset          = 1'b1;
		stall          = 1'b0;
		squash         = 1'b0;
		squash_target  = 32'd0;
		imem_valid     = 1'b1;
		resolve_valid  = 1'b0;
		resolve_pc     = 32'd0;
		resolve_target = 32'd0;
		resolve_taken  = 1'b0;
		for (int a = 0; a < mem_words; a++) begin
			mem[a] = {random_instr(), random_instr()};
		end
		// fixed words: addi x1 x0 1, beq x1 x2 0, jal x0 16
		mem[0][31:0]  = 32'h0010_0093;
		mem[32][31:0] = 32'h0020_8063;
		mem[32][63:32] = 32'h0100_006f;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;

		// random traffic, resolves often aimed at the current pc
		for (int n = 0; n < n_random; n++) begin
			r              = $urandom;
			stall          = (r[2:0] == 3'd0);
			imem_valid     = (r[5:3] != 3'd0);
			squash         = (r[9:6] == 4'd0);
			squash_target  = {22'd0, r[17:10], 2'b00};
			resolve_valid  = (r[20:18] == 3'd0);
			resolve_pc     = r[21] ? model_pc : {22'd0, r[29:22], 2'b00};
			resolve_taken  = r[30];
			resolve_target = {22'd0, 8'($urandom), 2'b00};
			next_cycle();
		end

		// directed btb sequence
		stall         = 1'b0;
		squash        = 1'b0;
		imem_valid    = 1'b1;
		resolve_valid = 1'b0;
		train(p_branch, t_branch, 1'b1);
		redirect(p_branch, 1'b1);
		repeat (2) next_cycle();
		train(p_jal, t_jal, 1'b1);
		redirect(p_jal, 1'b0);
		repeat (2) next_cycle();
		// not taken goes sequential
		train(p_branch, t_branch, 1'b0);
		redirect(p_branch, 1'b0);
		repeat (2) next_cycle();
		// aliasing slot steals the entry
		train(p_branch, t_branch, 1'b1);
		train(p_alias, 32'h0000_0200, 1'b1);
		redirect(p_branch, 1'b0);
		repeat (2) next_cycle();
		// squash beats a live prediction
		train(p_branch, t_branch, 1'b1);
		redirect(p_branch, 1'b0);
		redirect(32'h0000_0080, 1'b0);
		repeat (2) next_cycle();

		$display("%0d errors", error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#((n_random + n_directed + 200) * 10);
		$display("timeout: the run did not reach its end in time");
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== tb.f ====
hw/front_end_pkg.sv
hw/fetch_bus_if.sv
hw/fetch_unit.sv
hw/inst_decoder.sv
hw/branch_target_buffer.sv
hw/dispatch_stage.sv
dv/tb_dispatch_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dispatch stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_dispatch_stage \
	-Mdir "$build_dir" -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$build_dir/tb_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" "$log"; then
	exit 0
fi
exit 1
